// ==== rtl/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// bus address width, one full program counter
`define CPU_ADDR_W 16

// bus data width, one instruction word per read
`define CPU_DATA_W 16

// general purpose byte registers
`define CPU_NUM_REGS 4

// high address byte used by OUT writes
`define CPU_OUT_PAGE 8'hFF

`endif

// ==== rtl/cpu_pkg.sv ====
`include "cpu_config.svh"

package cpu_pkg;

  // one data value, one general register
  typedef logic [7:0] byte_t;

  // full bus address, same width as the program counter
  typedef logic [`CPU_ADDR_W-1:0] addr_t;

  // selects one of the general registers
  typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;

  // unlisted codes fall through as no operation
  typedef enum logic [3:0] {
    LDI  = 4'h0,
    ADD  = 4'h1,
    SUB  = 4'h2,
    PCHI = 4'h3,
    JLO  = 4'h4,
    JHI  = 4'h5,
    JC   = 4'h6,
    OUT  = 4'h7
  } opcode_e;

  // instruction word layout, msb first
  typedef struct packed {
    opcode_e  op;
    reg_idx_t rd;
    reg_idx_t rs;
    byte_t    imm;
  } instr_t;

endpackage

// ==== rtl/cpu_if.sv ====
// decoded instruction, handed from decode to execute
interface dec_if;
  import cpu_pkg::*;

  // one cycle strobe in the execute phase
  logic     valid;
  opcode_e  op;
  reg_idx_t rd;
  reg_idx_t rs;
  byte_t    imm;

  modport dec_src (output valid, op, rd, rs, imm);
  modport dec_dst (input valid, op, rd, rs, imm);
endinterface

// write-back and operand reads between execute and register file
interface res_if;
  import cpu_pkg::*;

  // write port
  logic     we;
  reg_idx_t wr_idx;
  byte_t    wr_val;

  // operand read ports, data comes back combinationally
  reg_idx_t rd_a_idx;
  reg_idx_t rd_b_idx;
  byte_t    rd_a;
  byte_t    rd_b;

  modport res_src (
    output we, wr_idx, wr_val, rd_a_idx, rd_b_idx,
    input  rd_a, rd_b
  );
  modport res_dst (
    input  we, wr_idx, wr_val, rd_a_idx, rd_b_idx,
    output rd_a, rd_b
  );
endinterface

// ==== rtl/pc.sv ====
`include "cpu_config.svh"

module pc (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   advance,
  input  logic                   pchitmp_load,
  input  logic                   local_jump,
  input  logic                   long_jump,
  input  cpu_pkg::byte_t         d,
  output logic [`CPU_ADDR_W-1:0] value
);
  import cpu_pkg::*;

  // high byte staged here until a long jump
  byte_t pc_hi_tmp;
  byte_t pc_lo;
  byte_t pc_hi;

  // temporary filled by PCHI
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pc_hi_tmp <= '0;
    end
    else if (pchitmp_load)
    begin
      pc_hi_tmp <= d;
    end
  end

  // jumps win over increment, though they never coincide
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pc_lo <= '0;
      pc_hi <= '0;
    end
    else if (long_jump)
    begin
      pc_lo <= d;
      pc_hi <= pc_hi_tmp;
    end
    else if (local_jump)
    begin
      // high byte untouched
      pc_lo <= d;
    end
    else if (advance)
    begin
      // low byte carries into high byte
      {pc_hi, pc_lo} <= {pc_hi, pc_lo} + 1'b1;
    end
  end

  assign value = {pc_hi, pc_lo};

endmodule

// ==== rtl/instr_decode.sv ====
`include "cpu_config.svh"

module instr_decode (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic [`CPU_ADDR_W-1:0] pc_value,
  output logic                   advance,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output logic [`CPU_ADDR_W-1:0] wb_adr,
  output logic [`CPU_DATA_W-1:0] wb_dat_w,
  input  logic [`CPU_DATA_W-1:0] wb_dat_r,
  input  logic                   wb_ack,
  output cpu_pkg::reg_idx_t      out_idx,
  input  cpu_pkg::byte_t         out_val,
  dec_if.dec_src                 dec
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {
    FETCH,
    EXEC,
    WRITE
  } phase_e;

  phase_e phase;
  instr_t ir;
  // cyc and stb always move together
  logic   bus_cyc;
  logic   fetch_done;
  logic   is_out;

  assign fetch_done = (phase == FETCH) && bus_cyc && wb_ack;
  assign is_out     = (ir.op == OUT);

  // phase sequencer and bus cycle control
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      phase   <= FETCH;
      bus_cyc <= 1'b0;
    end
    else
    begin
      case (phase)
        FETCH:
        begin
          // first cycle after reset or after an OUT write opens the read
          if (!bus_cyc)
          begin
            bus_cyc <= 1'b1;
          end
          else if (wb_ack)
          begin
            bus_cyc <= 1'b0;
            phase   <= EXEC;
          end
        end
        EXEC:
        begin
          phase <= WRITE;
          // OUT opens its write cycle right away
          if (is_out)
          begin
            bus_cyc <= 1'b1;
          end
        end
        WRITE:
        begin
          if (is_out)
          begin
            // hold until the slave takes the data
            if (bus_cyc && wb_ack)
            begin
              bus_cyc <= 1'b0;
              phase   <= FETCH;
            end
          end
          else
          begin
            // pc settles at this edge, so the next read starts at once
            bus_cyc <= 1'b1;
            phase   <= FETCH;
          end
        end
        default:
        begin
          phase   <= FETCH;
          bus_cyc <= 1'b0;
        end
      endcase
    end
  end

  // instruction register, loaded on the fetch ack
  always_ff @(posedge clk)
  begin
    if (fetch_done)
    begin
      ir <= instr_t'(wb_dat_r);
    end
  end

  // pc steps at the edge that ends the ack cycle
  assign advance = fetch_done;

  // bus outputs, stable for the whole cycle
  assign wb_cyc   = bus_cyc;
  assign wb_stb   = bus_cyc;
  assign wb_we    = (phase == WRITE) && is_out;
  assign wb_adr   = (phase == WRITE) ? {`CPU_OUT_PAGE, ir.imm} : pc_value;
  assign wb_dat_w = (phase == WRITE) ? {{(`CPU_DATA_W - 8){1'b0}}, out_val} : '0;

  // OUT sends the rs register
  assign out_idx = ir.rs;

  // fields for execute
  assign dec.valid = (phase == EXEC);
  assign dec.op    = ir.op;
  assign dec.rd    = ir.rd;
  assign dec.rs    = ir.rs;
  assign dec.imm   = ir.imm;

endmodule

// ==== rtl/alu_execute.sv ====
module alu_execute (
  input  logic           clk,
  input  logic           arst_n,
  dec_if.dec_dst         dec,
  res_if.res_src         res,
  output logic           pchitmp_load,
  output logic           local_jump,
  output logic           long_jump,
  output cpu_pkg::byte_t jump_target
);
  import cpu_pkg::*;

  // bit 8 is carry for ADD, borrow for SUB
  logic [8:0] sum;
  logic       carry;

  // operands come straight from the register file
  assign res.rd_a_idx = dec.rd;
  assign res.rd_b_idx = dec.rs;

  always_comb
  begin
    case (dec.op)
      ADD:     sum = {1'b0, res.rd_a} + {1'b0, res.rd_b};
      SUB:     sum = {1'b0, res.rd_a} - {1'b0, res.rd_b};
      default: sum = {1'b0, dec.imm};
    endcase
  end

  // control strobes, one cycle wide, valid in the write phase
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      res.we       <= 1'b0;
      carry        <= 1'b0;
      pchitmp_load <= 1'b0;
      local_jump   <= 1'b0;
      long_jump    <= 1'b0;
    end
    else
    begin
      res.we       <= 1'b0;
      pchitmp_load <= 1'b0;
      local_jump   <= 1'b0;
      long_jump    <= 1'b0;
      if (dec.valid)
      begin
        case (dec.op)
          LDI:
          begin
            res.we <= 1'b1;
          end
          ADD, SUB:
          begin
            res.we <= 1'b1;
            carry  <= sum[8];
          end
          PCHI:    pchitmp_load <= 1'b1;
          JLO:     local_jump   <= 1'b1;
          JHI:     long_jump    <= 1'b1;
          // taken only with carry from an earlier ADD or SUB
          JC:      long_jump    <= carry;
          default: ;
        endcase
      end
    end
  end

  // write-back data and jump byte
  always_ff @(posedge clk)
  begin
    if (dec.valid)
    begin
      res.wr_idx  <= dec.rd;
      res.wr_val  <= sum[7:0];
      jump_target <= dec.imm;
    end
  end

endmodule

// ==== rtl/reg_result.sv ====
`include "cpu_config.svh"

module reg_result (
  input  logic              clk,
  input  logic              arst_n,
  res_if.res_dst            res,
  input  cpu_pkg::reg_idx_t out_idx,
  output cpu_pkg::byte_t    out_val
);
  import cpu_pkg::*;

  byte_t regs [`CPU_NUM_REGS];

  // all registers start at zero
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < `CPU_NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (res.we)
    begin
      regs[res.wr_idx] <= res.wr_val;
    end
  end

  // two operand ports for execute
  assign res.rd_a = regs[res.rd_a_idx];
  assign res.rd_b = regs[res.rd_b_idx];

  // third port feeds OUT write data
  assign out_val = regs[out_idx];

endmodule

// ==== rtl/cpu_core.sv ====
`include "cpu_config.svh"

module cpu_core (
  input  logic                   clk,
  input  logic                   arst_n,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output logic [`CPU_ADDR_W-1:0] wb_adr,
  output logic [`CPU_DATA_W-1:0] wb_dat_w,
  input  logic [`CPU_DATA_W-1:0] wb_dat_r,
  input  logic                   wb_ack
);
  import cpu_pkg::*;

  // counter controls and value
  logic                   advance;
  logic                   pchitmp_load;
  logic                   local_jump;
  logic                   long_jump;
  byte_t                  jump_target;
  addr_t                  pc_value;

  // OUT data path
  reg_idx_t out_idx;
  byte_t    out_val;

  dec_if dec_bus ();
  res_if res_bus ();

  pc u_pc (
    .clk          (clk),
    .arst_n       (arst_n),
    .advance      (advance),
    .pchitmp_load (pchitmp_load),
    .local_jump   (local_jump),
    .long_jump    (long_jump),
    .d            (jump_target),
    .value        (pc_value)
  );

  instr_decode u_instr_decode (
    .clk      (clk),
    .arst_n   (arst_n),
    .pc_value (pc_value),
    .advance  (advance),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .out_idx  (out_idx),
    .out_val  (out_val),
    .dec      (dec_bus.dec_src)
  );

  alu_execute u_alu_execute (
    .clk          (clk),
    .arst_n       (arst_n),
    .dec          (dec_bus.dec_dst),
    .res          (res_bus.res_src),
    .pchitmp_load (pchitmp_load),
    .local_jump   (local_jump),
    .long_jump    (long_jump),
    .jump_target  (jump_target)
  );

  reg_result u_reg_result (
    .clk     (clk),
    .arst_n  (arst_n),
    .res     (res_bus.res_dst),
    .out_idx (out_idx),
    .out_val (out_val)
  );

endmodule

// ==== tb/cpu_core_chk.sv ====
`include "cpu_config.svh"

module cpu_core_chk (
  input logic                   clk,
  input logic                   arst_n,
  input logic                   wb_cyc,
  input logic                   wb_stb,
  input logic                   wb_we,
  input logic [`CPU_ADDR_W-1:0] wb_adr,
  input logic [`CPU_DATA_W-1:0] wb_dat_w,
  input logic                   wb_ack
);

  // failures per rule
  int stb_errs;
  int hold_errs;
  int reset_errs;

  // strobe only inside a bus cycle
  stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n) wb_stb |-> wb_cyc)
  else
  begin
    stb_errs++;
    $error("wb_stb high while wb_cyc is low");
  end

  // master holds the request until the slave acks
  hold_until_ack: assert property (
    @(posedge clk) disable iff (!arst_n)
      (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w))
  )
  else
  begin
    hold_errs++;
    $error("wb_adr, wb_we or wb_dat_w changed before wb_ack");
  end

  // no bus cycle while in reset
  idle_in_reset: assert property (@(posedge clk) !arst_n |-> !wb_cyc)
  else
  begin
    reset_errs++;
    $error("wb_cyc high during reset");
  end

endmodule

bind cpu_core cpu_core_chk u_chk (
  .clk      (clk),
  .arst_n   (arst_n),
  .wb_cyc   (wb_cyc),
  .wb_stb   (wb_stb),
  .wb_we    (wb_we),
  .wb_adr   (wb_adr),
  .wb_dat_w (wb_dat_w),
  .wb_ack   (wb_ack)
);

// ==== tb/cpu_core_tb.sv ====
`include "cpu_config.svh"

module cpu_core_tb;

  localparam int half_period     = 10;
  localparam int reset_cycles    = 16;
  localparam int num_words       = 23;
  localparam int num_txn         = 30;
  // generous budget per bus transaction
  localparam int cycles_per_txn  = 12;
  localparam int watchdog_cycles = reset_cycles + num_txn * cycles_per_txn;

  logic                   clk = 1'b0;
  logic                   arst_n;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [`CPU_ADDR_W-1:0] wb_adr;
  logic [`CPU_DATA_W-1:0] wb_dat_w;
  logic [`CPU_DATA_W-1:0] wb_dat_r;
  logic                   wb_ack;

  // memory model state
  logic [`CPU_DATA_W-1:0] mem [65536];
  logic [1:0]             wait_left;
  integer                 seed;

  int check_errors;
  int extra_txns;
  int ack_count;

  // program image with the address in the upper half and the instruction in the lower
  localparam logic [31:0] prog_image [num_words] = '{
    32'h0000_00C8,  // LDI r0, C8
    32'h0001_0450,  // LDI r1, 50
    32'h0002_1100,  // ADD r0, r1 -> 18 with carry
    32'h0003_7001,  // OUT r0 -> FF01
    32'h0004_6010,  // JC 10 taken
    32'h0010_2400,  // SUB r1, r0 -> 38 without borrow
    32'h0011_7102,  // OUT r1 -> FF02
    32'h0012_2100,  // SUB r0, r1 -> E0 with borrow
    32'h0013_7003,  // OUT r0 -> FF03
    32'h0014_0805,  // LDI r2, 05
    32'h0015_0C07,  // LDI r3, 07
    32'h0016_1B00,  // ADD r2, r3 -> 0C without carry
    32'h0017_6040,  // JC 40 falls through
    32'h0018_7204,  // OUT r2 -> FF04
    32'h0019_4030,  // JLO 30
    32'h0030_3012,  // PCHI 12
    32'h0031_5034,  // JHI 34 -> 1234
    32'h1234_7305,  // OUT r3 -> FF05
    32'h1235_04FF,  // LDI r1, FF
    32'h1236_40FF,  // JLO FF -> 12FF
    32'h12FF_1500,  // ADD r1, r1 -> FE and pc crosses into 1300
    32'h1300_7106,  // OUT r1 -> FF06
    32'h1301_4001   // JLO 01 spins here
  };

  // expected transactions as {we, adr, low data byte}
  // fetch rows hold the instruction byte for reference
  localparam logic [24:0] expected_txn [num_txn] = '{
    {1'b0, 16'h0000, 8'hC8}, {1'b0, 16'h0001, 8'h50}, {1'b0, 16'h0002, 8'h00},
    {1'b0, 16'h0003, 8'h01}, {1'b1, 16'hFF01, 8'h18}, {1'b0, 16'h0004, 8'h10},
    {1'b0, 16'h0010, 8'h00}, {1'b0, 16'h0011, 8'h02}, {1'b1, 16'hFF02, 8'h38},
    {1'b0, 16'h0012, 8'h00}, {1'b0, 16'h0013, 8'h03}, {1'b1, 16'hFF03, 8'hE0},
    {1'b0, 16'h0014, 8'h05}, {1'b0, 16'h0015, 8'h07}, {1'b0, 16'h0016, 8'h00},
    {1'b0, 16'h0017, 8'h40}, {1'b0, 16'h0018, 8'h04}, {1'b1, 16'hFF04, 8'h0C},
    {1'b0, 16'h0019, 8'h30}, {1'b0, 16'h0030, 8'h12}, {1'b0, 16'h0031, 8'h34},
    {1'b0, 16'h1234, 8'h05}, {1'b1, 16'hFF05, 8'h07}, {1'b0, 16'h1235, 8'hFF},
    {1'b0, 16'h1236, 8'hFF}, {1'b0, 16'h12FF, 8'h00}, {1'b0, 16'h1300, 8'h06},
    {1'b1, 16'hFF06, 8'hFE}, {1'b0, 16'h1301, 8'h01}, {1'b0, 16'h1301, 8'h01}
  };

  cpu_core UUT (
    .clk      (clk),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  always #(half_period) clk = ~clk;

  // unused words decode as no operation with low bits mixing the whole address
  function automatic logic [15:0] fill_word(input logic [15:0] adr);
    fill_word = {4'hF, adr[11:0] ^ {adr[15:12], adr[15:12], adr[15:12]}};
  endfunction

  function automatic int protocol_errors();
    protocol_errors = UUT.u_chk.stb_errs + UUT.u_chk.hold_errs + UUT.u_chk.reset_errs;
  endfunction

  function automatic int total_errors();
    total_errors = check_errors + extra_txns + protocol_errors();
  endfunction

  task automatic print_counts();
    $display("errors: %0d total, %0d value checks, %0d extra transactions, %0d protocol",
             total_errors(), check_errors, extra_txns, protocol_errors());
  endtask

  // mid-cycle sample of the next acknowledged transaction
  task automatic wait_for_ack();
    @(negedge clk);
    while (!(wb_cyc && wb_stb && wb_ack))
    begin
      @(negedge clk);
    end
  endtask

  task automatic compare_txn(input int row, input logic [24:0] want);
    assert (wb_we === want[24])
    else
    begin
      $display("CHECK FAILED txn %0d wb_we: got %h expected %h", row, wb_we, want[24]);
      check_errors++;
    end
    assert (wb_adr === want[23:8])
    else
    begin
      $display("CHECK FAILED txn %0d wb_adr: got %h expected %h", row, wb_adr, want[23:8]);
      check_errors++;
    end
    // OUT data carries the register in the low byte and zero above it
    assert (!want[24] || wb_dat_w === {8'h00, want[7:0]})
    else
    begin
      $display("CHECK FAILED txn %0d wb_dat_w: got %h expected %h", row, wb_dat_w,
               {8'h00, want[7:0]});
      check_errors++;
    end
  endtask

  // memory model with a registered ack after 0 to 3 random wait cycles
  initial
  begin
    seed = 32'hd992_8296;
    for (int a = 0; a < 65536; a++)
    begin
      mem[a[15:0]] = fill_word(a[15:0]);
    end
    for (int i = 0; i < num_words; i++)
    begin
      mem[prog_image[i][31:16]] = prog_image[i][15:0];
    end
    wb_ack    <= 1'b0;
    wb_dat_r  <= '0;
    wait_left <= 2'($random(seed));
    forever
    begin
      @(posedge clk);
      if (wb_ack)
      begin
        // single cycle ack
        wb_ack <= 1'b0;
      end
      else if (wb_cyc && wb_stb)
      begin
        if (wait_left != 2'd0)
        begin
          wait_left <= wait_left - 2'd1;
        end
        else
        begin
          wb_ack    <= 1'b1;
          wb_dat_r  <= wb_we ? '0 : mem[wb_adr];
          wait_left <= 2'($random(seed));
        end
      end
    end
  end

  // independent ack count where anything past the table is unexpected
  always @(negedge clk)
  begin
    if (wb_cyc && wb_stb && wb_ack)
    begin
      if (ack_count >= num_txn)
      begin
        $display("bus transaction %0d came after the expected table ended", ack_count);
        extra_txns++;
      end
      ack_count++;
    end
  end

  // reset then walk the expected table
  initial
  begin
    arst_n <= 1'b0;
    repeat (reset_cycles) @(posedge clk);
    arst_n <= 1'b1;
    for (int i = 0; i < num_txn; i++)
    begin
      wait_for_ack();
      compare_txn(i, expected_txn[i]);
    end
    print_counts();
    if (total_errors() == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: the expected transactions did not finish in %0d cycles",
             watchdog_cycles);
    print_counts();
    $display("Something failed");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/cpu_if.sv
rtl/pc.sv
rtl/instr_decode.sv
rtl/alu_execute.sv
rtl/reg_result.sv
rtl/cpu_core.sv
tb/cpu_core_chk.sv
tb/cpu_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_core_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS SIM_ARGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
